/* Makefile */
# Verilator flow for the core testbench: make compile, make run, make clean

VERILATOR ?= verilator
TOP       ?= coreTb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing -j $(JOBS)

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard common/* hdl/*.sv decode/*.sv execute/*.sv result/*.sv dv/*)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Simulation PASSED$$" $(LOG) || { echo "no pass line found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/corePkg.sv */
// shared types for the pipeline stages, imported by every core module that uses them
`default_nettype none

`include "coreSettings.svh"

package corePkg;

  typedef logic [`XLEN-1:0] wordT;
  typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor,
    aluSlt, aluSltu, aluSll, aluSrl, aluSra,
    aluPassB                              // lui
  } aluOpT;

  typedef enum logic {
    resAlu,
    resLink                               // pc + 4 for jal/jalr
  } resultSelT;

  typedef enum logic [3:0] {
    brNone, brEq, brNe, brLt, brGe, brLtu, brGeu,
    brJump, brJumpReg
  } branchT;

  //////////////////////////////////////////////////
  // stage payloads
  //////////////////////////////////////////////////
  typedef struct packed {
    logic      valid;
    wordT      pc;
    regIdxT    rs1;
    regIdxT    rs2;
    wordT      rs1Val;
    wordT      rs2Val;
    wordT      imm;
    regIdxT    rd;
    logic      regWrite;
    aluOpT     aluOp;
    logic      pcAsA;                     // auipc
    logic      immAsB;
    branchT    branch;
    resultSelT resultSel;
  } decodedT;

  typedef struct packed {
    logic      valid;
    wordT      pc;
    regIdxT    rd;
    logic      regWrite;
    wordT      aluResult;
    wordT      linkAddr;
    resultSelT resultSel;
  } execT;

endpackage

`default_nettype wire

/* common/coreSettings.svh */
// core-wide widths, reset PC and opcode values, included by the package and RTL that need them
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath
`define XLEN       32
`define REG_COUNT  32
`define RESET_PC   32'h0000_0000

// base opcodes still supported
`define OP_OP      7'b0110011
`define OP_IMM     7'b0010011
`define OP_LUI     7'b0110111
`define OP_AUIPC   7'b0010111
`define OP_JAL     7'b1101111
`define OP_JALR    7'b1100111
`define OP_BRANCH  7'b1100011

`endif

/* decode/decodeUnit.sv */
// instruction decode, immediate generation and operand read for the execute stage register
`timescale 1ns/1ps
`default_nettype none

`include "coreSettings.svh"

module decodeUnit import corePkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic        stall,
  input  logic [31:0] instrD,
  input  wordT        pcD,
  input  logic        validD,
  input  logic        wrEn,
  input  regIdxT      wrIdx,
  input  wordT        wrData,
  output decodedT     decoded
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       altBit;                     // funct7[5] selects sub and sra
  regIdxT     rs1, rs2, rd;
  wordT       immI, immU, immJ, immB;
  wordT       rs1Val, rs2Val;
  aluOpT      funcOp;

  assign opcode = instrD[6:0];
  assign rd     = instrD[11:7];
  assign funct3 = instrD[14:12];
  assign rs1    = instrD[19:15];
  assign rs2    = instrD[24:20];
  assign altBit = instrD[30];

  //////////////////////////////////////////////////
  // immediates
  //////////////////////////////////////////////////
  assign immI = {{20{instrD[31]}}, instrD[31:20]};
  assign immU = {instrD[31:12], 12'b0};
  assign immJ = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
  assign immB = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};

  regFile regs (
    .clk, .rstN, .stall,
    .rdIdxA(rs1), .rdIdxB(rs2),
    .wrEn, .wrIdx, .wrData,
    .rdDataA(rs1Val), .rdDataB(rs2Val)
  );

  // funct3 to alu op for both OP and OP-IMM
  always_comb begin
    case (funct3)
      3'b000:  funcOp = (altBit && opcode == `OP_OP) ? aluSub : aluAdd;
      3'b001:  funcOp = aluSll;
      3'b010:  funcOp = aluSlt;
      3'b011:  funcOp = aluSltu;
      3'b100:  funcOp = aluXor;
      3'b101:  funcOp = altBit ? aluSra : aluSrl;
      3'b110:  funcOp = aluOr;
      default: funcOp = aluAnd;
    endcase
  end

  always_comb begin
    decoded        = '0;
    decoded.valid  = validD;
    decoded.pc     = pcD;
    decoded.rs1    = rs1;
    decoded.rs2    = rs2;
    decoded.rs1Val = rs1Val;
    decoded.rs2Val = rs2Val;
    decoded.rd     = rd;
    decoded.aluOp  = aluAdd;
    case (opcode)
      `OP_OP: begin
        decoded.regWrite = 1'b1;
        decoded.aluOp    = funcOp;
      end
      `OP_IMM: begin
        decoded.regWrite = 1'b1;
        decoded.aluOp    = funcOp;
        decoded.imm      = immI;
        decoded.immAsB   = 1'b1;
      end
      `OP_LUI: begin
        decoded.regWrite = 1'b1;
        decoded.aluOp    = aluPassB;
        decoded.imm      = immU;
        decoded.immAsB   = 1'b1;
      end
      `OP_AUIPC: begin
        decoded.regWrite = 1'b1;
        decoded.imm      = immU;
        decoded.pcAsA    = 1'b1;
        decoded.immAsB   = 1'b1;
      end
      `OP_JAL: begin
        decoded.regWrite  = 1'b1;
        decoded.imm       = immJ;
        decoded.branch    = brJump;
        decoded.resultSel = resLink;
      end
      `OP_JALR: begin
        decoded.regWrite  = 1'b1;
        decoded.imm       = immI;
        decoded.branch    = brJumpReg;
        decoded.resultSel = resLink;
      end
      `OP_BRANCH: begin
        decoded.imm = immB;
        case (funct3)
          3'b000:  decoded.branch = brEq;
          3'b001:  decoded.branch = brNe;
          3'b100:  decoded.branch = brLt;
          3'b101:  decoded.branch = brGe;
          3'b110:  decoded.branch = brLtu;
          3'b111:  decoded.branch = brGeu;
          default: decoded.branch = brNone;
        endcase
      end
      default: ;                          // unsupported opcode retires with no write
    endcase
  end

endmodule

`default_nettype wire

/* decode/regFile.sv */
// integer register file read in decode and written from the result stage
`timescale 1ns/1ps
`default_nettype none

`include "coreSettings.svh"

module regFile import corePkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  logic   stall,
  input  regIdxT rdIdxA,
  input  regIdxT rdIdxB,
  input  logic   wrEn,
  input  regIdxT wrIdx,
  input  wordT   wrData,
  output wordT   rdDataA,
  output wordT   rdDataB
);

  wordT regs [`REG_COUNT];
  logic wrActive;

  // x0 is never stored, no writes while held in reset or stalled
  assign wrActive = wrEn & rstN & ~stall & (wrIdx != '0);

  always_ff @(posedge clk) begin
    if (wrActive) regs[wrIdx] <= wrData;
  end

  // write-through so decode sees the value retiring this cycle
  assign rdDataA = (rdIdxA == '0)                    ? '0     :
                   (wrActive && wrIdx == rdIdxA)     ? wrData : regs[rdIdxA];
  assign rdDataB = (rdIdxB == '0)                    ? '0     :
                   (wrActive && wrIdx == rdIdxB)     ? wrData : regs[rdIdxB];

endmodule

`default_nettype wire

/* dv/refModel.svh */
// architectural RV32I model and typed compare tasks, included inside the testbench module
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

typedef wordT regArrayT [`REG_COUNT];

// one OP or OP-IMM result, alt is instr bit 30 where it selects sub or sra
function automatic wordT aluModel(input logic [2:0] f3, input logic alt,
                                  input wordT a, input wordT b);
  wordT r;
  case (f3)
    3'd0: r = alt ? a - b : a + b;
    3'd1: r = a << b[4:0];
    3'd2: r = wordT'($signed(a) < $signed(b));
    3'd3: r = wordT'(a < b);
    3'd4: r = a ^ b;
    3'd5: begin
      if (alt) r = $signed(a) >>> b[4:0];
      else     r = a >> b[4:0];
    end
    3'd6: r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

// steps one instruction, rd and value read zero when nothing is written
function automatic void stepModel(input logic [31:0] ins, input wordT curPc,
                                  input regArrayT regs, output wordT nextPc,
                                  output regIdxT rd, output wordT value);
  wordT a, b, immI, immB, immJ, res;
  logic wr, take;
  a      = regs[ins[19:15]];
  b      = regs[ins[24:20]];
  immI   = {{20{ins[31]}}, ins[31:20]};
  immB   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
  immJ   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
  nextPc = curPc + 4;
  wr     = 1'b1;
  take   = 1'b0;
  res    = '0;
  case (ins[6:0])
    `OP_OP:    res = aluModel(ins[14:12], ins[30], a, b);
    `OP_IMM:   res = aluModel(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, immI);
    `OP_LUI:   res = {ins[31:12], 12'b0};
    `OP_AUIPC: res = curPc + {ins[31:12], 12'b0};
    `OP_JAL: begin
      res    = curPc + 4;
      nextPc = curPc + immJ;
    end
    `OP_JALR: begin
      res    = curPc + 4;                 // link uses old rs1 even when rd == rs1
      nextPc = (a + immI) & ~32'd1;
    end
    `OP_BRANCH: begin
      wr = 1'b0;
      case (ins[14:12])
        3'd0:    take = a == b;
        3'd1:    take = a != b;
        3'd4:    take = $signed(a) < $signed(b);
        3'd5:    take = $signed(a) >= $signed(b);
        3'd6:    take = a < b;
        3'd7:    take = a >= b;
        default: take = 1'b0;
      endcase
      if (take) nextPc = curPc + immB;
    end
    default: wr = 1'b0;                   // unsupported opcode
  endcase
  rd    = wr ? ins[11:7] : '0;
  value = (rd != '0) ? res : '0;
endfunction

task automatic checkWord(input string name, input wordT expected, input wordT actual);
  if (expected !== actual)
    reportFailure($sformatf("[FAIL] %s: expected %h, actual %h", name, expected, actual));
endtask

task automatic checkReg(input string name, input regIdxT expected, input regIdxT actual);
  if (expected !== actual)
    reportFailure($sformatf("[FAIL] %s: expected x%0d, actual x%0d", name, expected, actual));
endtask

`endif

/* dv/coreTb.sv */
// self-checking testbench that runs a generated program on coreTop against a reference model
`timescale 1ns/1ps
`default_nettype none

`include "coreSettings.svh"

module coreTb import corePkg::*; ();

  localparam int ClkPeriod   = 40;
  localparam int ResetCycles = 10;
  localparam int MemWords    = 512;
  localparam int IdxW        = $clog2(MemWords);
  localparam int RandomLen   = 300;
  localparam int MaxStalls   = 200;      // stall budget that bounds the watchdog

  logic        clk;
  logic        rstN;
  logic        stall;
  logic [31:0] instr;
  wordT        pc;
  logic        retireValid;
  wordT        retirePc;
  regIdxT      retireRd;
  wordT        retireValue;

  logic [31:0] progMem [MemWords];
  int          progLen;
  int          sectionStart [6];
  logic        haltSeen;
  wordT        modelPc;

  task automatic reportFailure(input string detail);
    $display("%s", detail);
    $display("Simulation FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  `include "refModel.svh"

  regArrayT modelRegs;

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  assign instr = progMem[pc[IdxW+1:2]];  // combinational instruction memory

  coreTop UUT (
    .clk, .rstN, .stall, .instr, .pc,
    .retireValid, .retirePc, .retireRd, .retireValue
  );

  //////////////////////////////////////////////////
  // instruction encoding and program generation
  //////////////////////////////////////////////////
  function automatic logic [31:0] encR(input logic [6:0] f7, input int rs2, input int rs1,
                                       input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), `OP_OP};
  endfunction

  function automatic logic [31:0] encI(input int imm, input int rs1, input logic [2:0] f3,
                                       input int rd, input logic [6:0] opc);
    return {imm[11:0], 5'(rs1), f3, 5'(rd), opc};
  endfunction

  function automatic logic [31:0] encU(input int imm, input int rd, input logic [6:0] opc);
    return {imm[19:0], 5'(rd), opc};
  endfunction

  function automatic logic [31:0] encB(input int off, input int rs2, input int rs1,
                                       input logic [2:0] f3);
    return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], `OP_BRANCH};
  endfunction

  function automatic logic [31:0] encJ(input int off, input int rd);
    return {off[20], off[10:1], off[11], off[19:12], 5'(rd), `OP_JAL};
  endfunction

  task automatic emit(input logic [31:0] ins);
    progMem[progLen] = ins;
    progLen++;
  endtask

  function automatic string testName(input wordT addr);
    string name;
    name = "register init";
    if (addr >= wordT'(4 * sectionStart[1])) name = "dependent alu";
    if (addr >= wordT'(4 * sectionStart[2])) name = "immediates";
    if (addr >= wordT'(4 * sectionStart[3])) name = "x0 writes";
    if (addr >= wordT'(4 * sectionStart[4])) name = "branches";
    if (addr >= wordT'(4 * sectionStart[5])) name = "random program";
    return name;
  endfunction

  task automatic buildProgram();
    int   kind, f3, rd, rs1, rs2, imm;
    logic alt;
    for (int i = 0; i < MemWords; i++) progMem[i] = encI(i, 0, 3'd0, 0, `OP_IMM);  // tagged nop
    progLen = 0;
    for (int r = 1; r < 32; r++) emit(encI($urandom, 0, 3'd0, r, `OP_IMM));
    // chains at distance 1 and 2, then 1 and 3
    sectionStart[1] = progLen;
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < 10; i++) begin
        f3 = (i < 8) ? i : ((i == 8) ? 0 : 5);
        emit(encR((i >= 8) ? 7'h20 : 7'h00, 8 + i - pass, 9 + i, 3'(f3), 10 + i));
      end
    end
    sectionStart[2] = progLen;
    for (int i = 0; i < 8; i++) begin
      imm = (i == 1 || i == 5) ? $urandom % 32 : $urandom;
      emit(encI(imm, 19 + i, 3'(i), 20 + i, `OP_IMM));
    end
    emit(encI(32'h400 + $urandom % 32, 27, 3'd5, 28, `OP_IMM));     // srai
    emit(encU($urandom, 29, `OP_LUI));
    emit(encU($urandom, 30, `OP_AUIPC));
    emit(encI(-1, 30, 3'd0, 31, `OP_IMM));
    sectionStart[3] = progLen;
    emit(encI(123, 1, 3'd0, 0, `OP_IMM));
    emit(encR(7'h00, 2, 1, 3'd0, 0));
    emit(encU(32'hfffff, 0, `OP_LUI));
    emit(encR(7'h00, 0, 0, 3'd6, 1));    // reads x0 right after its writes
    emit(encI(-5, 0, 3'd0, 2, `OP_IMM));
    // -5 against -1 then -1 against itself so every kind goes both ways
    sectionStart[4] = progLen;
    emit(encI(-1, 0, 3'd0, 3, `OP_IMM));
    for (int f = 0; f < 8; f++) begin
      if (f == 2 || f == 3) continue;
      emit(encB(12, 3, 2, 3'(f)));
      emit(encI(1, 4, 3'd0, 4, `OP_IMM));
      emit(encI(2, 4, 3'd0, 4, `OP_IMM));
      emit(encB(8, 3, 3, 3'(f)));
      emit(encI(1, 5, 3'd0, 5, `OP_IMM));
    end
    emit(encJ(8, 6));
    emit(encI(99, 0, 3'd0, 7, `OP_IMM));
    emit(encU(0, 7, `OP_AUIPC));
    emit(encI(13, 7, 3'd0, 8, `OP_JALR)); // target auipc + 12
    emit(encI(77, 0, 3'd0, 9, `OP_IMM));
    emit(encR(7'h00, 8, 6, 3'd0, 9));
    sectionStart[5] = progLen;
    while (progLen < sectionStart[5] + RandomLen) begin
      kind = $urandom % 10;
      f3   = $urandom % 8;
      rd   = $urandom % 32;
      rs1  = $urandom % 32;
      rs2  = $urandom % 32;
      if (progLen > sectionStart[5] + RandomLen - 5 && kind < 2) kind = 9;  // stay before the end
      if (kind == 0) begin
        if (f3 == 2 || f3 == 3) f3 = f3 - 2;
        emit(encB(4 * (1 + $urandom % 4), rs2, rs1, 3'(f3)));
      end else if (kind == 1) begin
        emit(encJ(4 * (1 + $urandom % 4), rd));
      end else if (kind == 2) begin
        emit(encU($urandom, rd, ($urandom % 2) ? `OP_LUI : `OP_AUIPC));
      end else if (kind < 6) begin
        if (f3 == 1)      imm = $urandom % 32;
        else if (f3 == 5) imm = ($urandom % 2) * 32'h400 + $urandom % 32;
        else              imm = $urandom;
        emit(encI(imm, rs1, 3'(f3), rd, `OP_IMM));
      end else begin
        alt = (f3 == 0 || f3 == 5) && ($urandom % 2);
        emit(encR(alt ? 7'h20 : 7'h00, rs2, rs1, 3'(f3), rd));
      end
    end
    emit(encJ(0, 0));                    // final self-loop
  endtask

  //////////////////////////////////////////////////
  // stimulus, compare and watchdog
  //////////////////////////////////////////////////
  initial begin
    int stallsUsed;
    stallsUsed = 0;
    rstN       = 1'b0;
    stall      = 1'b0;
    void'($urandom(32'h406e));
    buildProgram();
    repeat (ResetCycles) @(negedge clk);
    checkWord("reset pc", `RESET_PC, pc);
    rstN = 1'b1;
    while (!haltSeen) begin
      @(negedge clk);
      stall = (stallsUsed < MaxStalls) && ($urandom % 6 == 0);
      if (stall) stallsUsed++;
    end
    stall = 1'b0;
    repeat (4) @(negedge clk);           // a few more self-loop retirements
    $display("Simulation PASSED");
    $finish;
  end

  initial begin : compareRetire
    wordT   nextPc, expValue, pcSeen;
    regIdxT expRd;
    string  name;
    logic   stallSeen;
    haltSeen  = 1'b0;
    stallSeen = 1'b0;
    pcSeen    = '0;
    modelPc   = `RESET_PC;
    foreach (modelRegs[i]) modelRegs[i] = '0;
    forever begin
      @(posedge clk);                    // outputs still hold the finished cycle
      if (stallSeen) checkWord("stall pc hold", pcSeen, pc);
      stallSeen = stall && rstN;
      pcSeen    = pc;
      if (retireValid && (!rstN || stall))
        reportFailure("retire reported while reset or stall was active");
      if (retireValid) begin
        stepModel(progMem[modelPc[IdxW+1:2]], modelPc, modelRegs, nextPc, expRd, expValue);
        name = testName(modelPc);
        checkWord({name, " pc"}, modelPc, retirePc);
        checkReg({name, " rd"}, expRd, retireRd);
        checkWord({name, " value"}, expValue, retireValue);
        if (expRd != '0) modelRegs[expRd] = expValue;
        if (nextPc == modelPc) haltSeen = 1'b1;
        modelPc = nextPc;
      end
    end
  end

  initial begin : watchdog
    @(posedge rstN);
    #((progLen * 4 + MaxStalls + ResetCycles + 20) * ClkPeriod);   // fill and drain margin
    reportFailure("watchdog timeout before the final self-loop retired");
  end

endmodule

`default_nettype wire

/* execute/executeUnit.sv */
// forwarding, ALU and branch resolution between the execute and result stage registers
`timescale 1ns/1ps
`default_nettype none

module executeUnit import corePkg::*; (
  input  decodedT decodedE,
  input  logic    fwdValid,
  input  regIdxT  fwdRd,
  input  wordT    fwdValue,
  output execT    executed,
  output logic    redirect,
  output wordT    redirectPc
);

  localparam int ShiftW = $clog2($bits(wordT));

  wordT              src1, src2;          // forwarded register values
  wordT              opA, opB, aluResult;
  logic [ShiftW-1:0] shamt;
  logic              isEq, isLt, isLtu, taken;

  //////////////////////////////////////////////////
  // forwarding from the result stage
  //////////////////////////////////////////////////
  assign src1 = (fwdValid && fwdRd == decodedE.rs1 && decodedE.rs1 != '0) ?
                fwdValue : decodedE.rs1Val;
  assign src2 = (fwdValid && fwdRd == decodedE.rs2 && decodedE.rs2 != '0) ?
                fwdValue : decodedE.rs2Val;

  assign opA   = decodedE.pcAsA  ? decodedE.pc  : src1;
  assign opB   = decodedE.immAsB ? decodedE.imm : src2;
  assign shamt = opB[ShiftW-1:0];

  always_comb begin
    aluResult = '0;
    case (decodedE.aluOp)
      aluAdd:   aluResult = opA + opB;
      aluSub:   aluResult = opA - opB;
      aluAnd:   aluResult = opA & opB;
      aluOr:    aluResult = opA | opB;
      aluXor:   aluResult = opA ^ opB;
      aluSlt:   aluResult[0] = $signed(opA) < $signed(opB);
      aluSltu:  aluResult[0] = opA < opB;
      aluSll:   aluResult = opA << shamt;
      aluSrl:   aluResult = opA >> shamt;
      aluSra:   aluResult = $signed(opA) >>> shamt;
      default:  aluResult = opB;          // pass-B
    endcase
  end

  //////////////////////////////////////////////////
  // branch resolution
  //////////////////////////////////////////////////
  assign isEq  = src1 == src2;
  assign isLt  = $signed(src1) < $signed(src2);
  assign isLtu = src1 < src2;

  always_comb begin
    case (decodedE.branch)
      brEq:      taken = isEq;
      brNe:      taken = ~isEq;
      brLt:      taken = isLt;
      brGe:      taken = ~isLt;
      brLtu:     taken = isLtu;
      brGeu:     taken = ~isLtu;
      brJump,
      brJumpReg: taken = 1'b1;
      default:   taken = 1'b0;
    endcase
  end

  assign redirect   = decodedE.valid & taken;
  assign redirectPc = (decodedE.branch == brJumpReg) ?
                      ((src1 + decodedE.imm) & ~wordT'(1)) :   // jalr clears bit 0
                      decodedE.pc + decodedE.imm;

  always_comb begin
    executed           = '0;
    executed.valid     = decodedE.valid;
    executed.pc        = decodedE.pc;
    executed.rd        = decodedE.rd;
    executed.regWrite  = decodedE.regWrite;
    executed.aluResult = aluResult;
    executed.linkAddr  = decodedE.pc + wordT'(4);
    executed.resultSel = decodedE.resultSel;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+common
+incdir+dv
common/corePkg.sv
hdl/pipeReg.sv
hdl/fetchUnit.sv
decode/regFile.sv
decode/decodeUnit.sv
execute/executeUnit.sv
result/resultUnit.sv
hdl/coreTop.sv
dv/coreTb.sv

/* hdl/coreTop.sv */
// top of the four-stage RV32I core, fed by a combinational instruction memory on pc/instr
`timescale 1ns/1ps
`default_nettype none

module coreTop import corePkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic        stall,
  input  logic [31:0] instr,
  output wordT        pc,
  output logic        retireValid,
  output wordT        retirePc,
  output regIdxT      retireRd,
  output wordT        retireValue
);

  // fetch to decode
  logic [31:0] instrD;
  wordT        pcD;
  logic        validD;

  // stage payloads
  decodedT     decoded, decodedE;
  execT        executed, resultR;

  // redirect from execute
  logic        redirect;
  wordT        redirectPc;

  // writeback and forwarding from result
  logic        wrEn, fwdValid;
  regIdxT      wrIdx, fwdRd;
  wordT        wrData, fwdValue;

  fetchUnit fetch (
    .clk, .rstN, .stall,
    .redirect, .redirectPc,
    .instr, .pc,
    .instrD, .pcD, .validD
  );

  decodeUnit decode (
    .clk, .rstN, .stall,
    .instrD, .pcD, .validD,
    .wrEn, .wrIdx, .wrData,
    .decoded
  );

  // flushed by a taken branch or jump
  pipeReg #(.payloadT(decodedT)) executeStage (
    .clk, .rstN, .stall, .flush(redirect), .d(decoded), .q(decodedE)
  );

  executeUnit execute (
    .decodedE, .fwdValid, .fwdRd, .fwdValue,
    .executed, .redirect, .redirectPc
  );

  pipeReg #(.payloadT(execT)) resultStage (
    .clk, .rstN, .stall, .flush(1'b0), .d(executed), .q(resultR)
  );

  resultUnit result (
    .stall, .resultR,
    .wrEn, .wrIdx, .wrData,
    .fwdValid, .fwdRd, .fwdValue,
    .retireValid, .retirePc, .retireRd, .retireValue
  );

endmodule

`default_nettype wire

/* hdl/fetchUnit.sv */
// PC register and fetch-to-decode instruction register, driven by redirects from execute
`timescale 1ns/1ps
`default_nettype none

`include "coreSettings.svh"

module fetchUnit import corePkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic        stall,
  input  logic        redirect,
  input  wordT        redirectPc,
  input  logic [31:0] instr,
  output wordT        pc,
  output logic [31:0] instrD,
  output wordT        pcD,
  output logic        validD
);

  wordT pcNext;

  // sequential or redirected fetch
  assign pcNext = redirect ? redirectPc : pc + wordT'(4);

  //////////////////////////////////////////////////
  // control state
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc     <= `RESET_PC;
      validD <= 1'b0;
    end else if (!stall) begin
      pc     <= pcNext;
      validD <= ~redirect;                // kill the wrong-path fetch
    end
  end

  // instruction and its pc for decode
  always_ff @(posedge clk) begin
    if (!stall) begin
      instrD <= instr;
      pcD    <= pc;
    end
  end

endmodule

`default_nettype wire

/* hdl/pipeReg.sv */
// stage register between two pipeline stages, instantiated once per payload type
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    stall,
  input  logic    flush,
  input  payloadT d,
  output payloadT q
);

  // stall wins over flush so a redirect seen during stall survives until release
  always_ff @(posedge clk) begin
    if (!rstN) begin
      q <= '0;                            // valid field low
    end else if (!stall) begin
      if (flush) q <= '0;                 // bubble
      else       q <= d;
    end
  end

endmodule

`default_nettype wire

/* result/resultUnit.sv */
// writeback selection, register write, forward value and retire reporting from the result register
`timescale 1ns/1ps
`default_nettype none

module resultUnit import corePkg::*; (
  input  logic   stall,
  input  execT   resultR,
  output logic   wrEn,
  output regIdxT wrIdx,
  output wordT   wrData,
  output logic   fwdValid,
  output regIdxT fwdRd,
  output wordT   fwdValue,
  output logic   retireValid,
  output wordT   retirePc,
  output regIdxT retireRd,
  output wordT   retireValue
);

  wordT value;
  logic writes;

  assign value  = (resultR.resultSel == resLink) ? resultR.linkAddr : resultR.aluResult;
  assign writes = resultR.valid & resultR.regWrite & (resultR.rd != '0);   // x0 dropped here

  // register file port, regFile blocks it during stall
  assign wrEn   = writes;
  assign wrIdx  = resultR.rd;
  assign wrData = value;

  // forward path to execute
  assign fwdValid = writes;
  assign fwdRd    = resultR.rd;
  assign fwdValue = value;

  //////////////////////////////////////////////////
  // retire port
  //////////////////////////////////////////////////
  assign retireValid = resultR.valid & ~stall;
  assign retirePc    = resultR.pc;
  assign retireRd    = writes ? resultR.rd : '0;
  assign retireValue = writes ? value : '0;

endmodule

`default_nettype wire
